/* rtl/fpu_isa_pkg.sv */
// ====================
// FPU instruction set: instruction word layout, function codes,
// per-function latencies and the double value type
// ====================
package fpu_isa_pkg;

	// One IEEE 754 double word
	typedef logic [63:0] value_t;

	// The instruction word read three ways
	// The opcode sits in the low seven bits of every view
	typedef union packed {
		struct packed {
			logic [24:0] rest;
			logic [6:0]  opcode;
		} any;
		// Two-operand format with func2 right above the opcode
		struct packed {
			logic [19:0] rest;
			logic [4:0]  func2;
			logic [6:0]  opcode;
		} f2;
		// One-operand format, only meaningful when func2 is FN_FLT1
		struct packed {
			logic [14:0] rest;
			logic [4:0]  func1;
			logic [4:0]  func2;
			logic [6:0]  opcode;
		} f1;
	} fpu_instr_t;

	// The only opcode this unit executes
	localparam logic [6:0] OP_FLT = 7'h53;

	// ====================
	// func2 codes
	localparam logic [4:0] FN_FLT1  = 5'h01;
	localparam logic [4:0] FN_SGNJ  = 5'h04;
	localparam logic [4:0] FN_SGNJN = 5'h05;
	localparam logic [4:0] FN_SGNJX = 5'h06;
	localparam logic [4:0] FN_FSEQ  = 5'h10;
	localparam logic [4:0] FN_FSNE  = 5'h11;
	localparam logic [4:0] FN_FSLT  = 5'h12;
	localparam logic [4:0] FN_FSLE  = 5'h13;

	// func1 codes, used under FN_FLT1
	localparam logic [4:0] FN_FABS    = 5'h01;
	localparam logic [4:0] FN_FNEG    = 5'h02;
	localparam logic [4:0] FN_ISNAN   = 5'h03;
	localparam logic [4:0] FN_FINITE  = 5'h04;
	localparam logic [4:0] FN_FTRUNC  = 5'h05;
	localparam logic [4:0] FN_FCVTS2D = 5'h06;

	// ====================
	// Cycles from start to done for each class of function
	localparam logic [3:0] LAT_SIMPLE = 4'd1;
	localparam logic [3:0] LAT_CVT    = 4'd2;
	localparam logic [3:0] LAT_TRUNC  = 4'd3;

	// Width of the latency counter
	localparam int CNT_W = 4;

endpackage

/* rtl/fpu_axil_pkg.sv */
// ====================
// FPU register map and AXI4-Lite constants
// ====================
package fpu_axil_pkg;

	// Byte address width of the register window
	localparam int ADDR_W = 5;

	// Register offsets, one 32-bit word each
	localparam logic [ADDR_W-1:0] REG_A_LO   = 5'h00;
	localparam logic [ADDR_W-1:0] REG_A_HI   = 5'h04;
	localparam logic [ADDR_W-1:0] REG_B_LO   = 5'h08;
	localparam logic [ADDR_W-1:0] REG_B_HI   = 5'h0C;
	localparam logic [ADDR_W-1:0] REG_INSTR  = 5'h10;
	localparam logic [ADDR_W-1:0] REG_STATUS = 5'h14;
	localparam logic [ADDR_W-1:0] REG_RES_LO = 5'h18;
	localparam logic [ADDR_W-1:0] REG_RES_HI = 5'h1C;

	// Response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Bit positions in the STATUS word
	localparam int ST_BUSY    = 0;
	localparam int ST_DONE    = 1;
	localparam int ST_ILLEGAL = 2;

endpackage

/* rtl/fpu_axil_write.sv */
// ====================
// FPU write side: AXI4-Lite write channels, operand and instruction
// registers, and the start pulse
// ====================
module fpu_axil_write (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [fpu_axil_pkg::ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [31:0]                     wdata,
	input  logic [3:0]                      wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic                            busy,
	output fpu_isa_pkg::value_t             op_a,
	output fpu_isa_pkg::value_t             op_b,
	output fpu_isa_pkg::fpu_instr_t         instr,
	output logic                            start
);
	import fpu_axil_pkg::*;

	logic accept;
	logic wr_ok;
	logic is_instr;

	// Address and data are taken in the same cycle, and only when
	// the previous response has been handed over
	assign accept  = awvalid && wvalid && !bvalid;
	assign awready = accept;
	assign wready  = accept;

	// Strobes are ignored and every write replaces a whole word

	assign is_instr = (awaddr == REG_INSTR);

	// A new instruction is refused while one is running or about to start.
	// STATUS and RES are read-only and anything else is unmapped
	always_comb begin
		case (awaddr)
			REG_A_LO, REG_A_HI, REG_B_LO, REG_B_HI: wr_ok = 1'b1;
			REG_INSTR: wr_ok = !(busy || start);
			default: wr_ok = 1'b0;
		endcase
	end

	// Write response and start pulse
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bvalid <= 1'b0;
			bresp  <= RESP_OKAY;
			start  <= 1'b0;
		end else begin
			// Start follows the accepted INSTR write by one cycle
			start <= accept && is_instr && wr_ok;
			if (accept) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Instruction register, loaded only by an accepted INSTR write
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instr <= '0;
		end else if (accept && is_instr && wr_ok) begin
			instr <= wdata;
		end
	end

	// Operand halves
	always_ff @(posedge clk) begin
		if (accept && wr_ok) begin
			case (awaddr)
				REG_A_LO: op_a[31:0]  <= wdata;
				REG_A_HI: op_a[63:32] <= wdata;
				REG_B_LO: op_b[31:0]  <= wdata;
				REG_B_HI: op_b[63:32] <= wdata;
				default: ;
			endcase
		end
	end

endmodule

/* rtl/fpu_latency_ctrl.sv */
// ====================
// FPU sequencing: counts cycles from start and signals done
// once the selected function's latency has passed
// ====================
module fpu_latency_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  fpu_isa_pkg::fpu_instr_t instr,
	output logic                    busy,
	output logic                    done,
	output logic                    illegal
);
	import fpu_isa_pkg::*;

	logic [CNT_W-1:0] cnt;
	logic [3:0]       lat;
	logic             bad_code;

	// ====================
	// Function decode
	// Unknown codes finish in a single cycle and are flagged
	always_comb begin
		lat      = LAT_SIMPLE;
		bad_code = 1'b1;
		if (instr.any.opcode == OP_FLT) begin
			case (instr.f2.func2)
				FN_FLT1: begin
					case (instr.f1.func1)
						FN_FABS, FN_FNEG, FN_ISNAN, FN_FINITE: bad_code = 1'b0;
						FN_FCVTS2D: begin
							lat      = LAT_CVT;
							bad_code = 1'b0;
						end
						FN_FTRUNC: begin
							lat      = LAT_TRUNC;
							bad_code = 1'b0;
						end
						default: bad_code = 1'b1;
					endcase
				end
				FN_FSEQ, FN_FSNE, FN_FSLT, FN_FSLE,
				FN_SGNJ, FN_SGNJN, FN_SGNJX: bad_code = 1'b0;
				default: bad_code = 1'b1;
			endcase
		end
	end

	// ====================
	// Cycle counter
	// The counter reads 1 in the first cycle after start, so done
	// appears exactly lat cycles after the start pulse
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= CNT_W'(1);
		end else if (done) begin
			// Busy drops on the same edge that ends done
			busy <= 1'b0;
			cnt  <= '0;
		end else if (busy) begin
			cnt <= cnt + CNT_W'(1);
		end
	end

	assign done    = busy && (cnt == lat);
	assign illegal = done && bad_code;

endmodule

/* rtl/fpu_exec.sv */
// ====================
// FPU datapath: sign, compare, classify, single to double
// conversion and a three-stage truncate pipeline
// ====================
module fpu_exec (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  fpu_isa_pkg::fpu_instr_t instr,
	input  fpu_isa_pkg::value_t     op_a,
	input  fpu_isa_pkg::value_t     op_b,
	output fpu_isa_pkg::value_t     result
);
	import fpu_isa_pkg::*;

	logic   a_nan, b_nan, any_nan;
	logic   both_zero;
	logic   cmp_eq, cmp_lt;
	value_t cvt_res;
	value_t trunc_res;

	// Truncate pipeline registers
	logic       s1_v, s2_v, s3_v;
	value_t     s1_val, s2_val, s3_val;
	logic       s1_small, s1_pass, s2_small, s2_pass;
	logic [5:0] s1_fbits;
	value_t     s2_mask;

	// ====================
	// Compare and classify
	assign a_nan     = (&op_a[62:52]) && (|op_a[51:0]);
	assign b_nan     = (&op_b[62:52]) && (|op_b[51:0]);
	assign any_nan   = a_nan || b_nan;
	// Plus and minus zero compare equal
	assign both_zero = ~|op_a[62:0] && ~|op_b[62:0];
	assign cmp_eq    = !any_nan && ((op_a == op_b) || both_zero);

	// Sign-magnitude ordering, reversed when both are negative
	always_comb begin
		if (any_nan || both_zero)
			cmp_lt = 1'b0;
		else if (op_a[63] != op_b[63])
			cmp_lt = op_a[63];
		else if (op_a[63])
			cmp_lt = op_a[62:0] > op_b[62:0];
		else
			cmp_lt = op_a[62:0] < op_b[62:0];
	end

	// ====================
	// Single to double conversion of A's low word
	always_comb begin
		if (op_a[30:23] == 8'h00) begin
			// Zero, and subnormals flushed to a signed zero
			cvt_res = {op_a[31], 63'd0};
		end else if (op_a[30:23] == 8'hFF) begin
			if (op_a[22:0] == 23'd0)
				cvt_res = {op_a[31], 11'h7FF, 52'd0};
			else
				// NaN payload kept, quiet bit forced on
				cvt_res = {op_a[31], 11'h7FF, 1'b1, op_a[21:0], 29'd0};
		end else begin
			// Rebias from 127 to 1023
			cvt_res = {op_a[31], {3'b000, op_a[30:23]} + 11'd896, op_a[22:0], 29'd0};
		end
	end

	// ====================
	// Truncate toward zero
	// Valid tags follow the operation started by start
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_v <= 1'b0;
			s2_v <= 1'b0;
			s3_v <= 1'b0;
		end else begin
			s1_v <= start;
			s2_v <= s1_v;
			s3_v <= s2_v;
		end
	end

	always_ff @(posedge clk) begin
		// Stage 1 looks at the exponent. Below 1023 the magnitude is under one,
		// from 1075 up there are no fraction bits (this covers inf and NaN)
		s1_val   <= op_a;
		s1_small <= op_a[62:52] < 11'd1023;
		s1_pass  <= op_a[62:52] >= 11'd1075;
		if (op_a[62:52] >= 11'd1023 && op_a[62:52] < 11'd1075)
			s1_fbits <= 6'(11'd1075 - op_a[62:52]);
		else
			s1_fbits <= 6'd0;

		// Stage 2 builds the mask that clears the fraction bits
		s2_val   <= s1_val;
		s2_small <= s1_small;
		s2_pass  <= s1_pass;
		s2_mask  <= {64{1'b1}} << s1_fbits;

		// Stage 3 applies it
		if (s2_pass)
			s3_val <= s2_val;
		else if (s2_small)
			s3_val <= {s2_val[63], 63'd0};
		else
			s3_val <= s2_val & s2_mask;
	end

	assign trunc_res = s3_v ? s3_val : '0;

	// ====================
	// Result select on the two instruction formats
	always_comb begin
		result = '0;
		if (instr.any.opcode == OP_FLT) begin
			case (instr.f2.func2)
				FN_FLT1: begin
					case (instr.f1.func1)
						FN_FABS:    result = {1'b0, op_a[62:0]};
						FN_FNEG:    result = {~op_a[63], op_a[62:0]};
						FN_ISNAN:   result = {63'd0, a_nan};
						FN_FINITE:  result = {63'd0, ~&op_a[62:52]};
						FN_FTRUNC:  result = trunc_res;
						FN_FCVTS2D: result = cvt_res;
						default:    result = '0;
					endcase
				end
				FN_FSEQ:  result = {63'd0, cmp_eq};
				FN_FSNE:  result = {63'd0, ~cmp_eq};
				FN_FSLT:  result = {63'd0, cmp_lt};
				FN_FSLE:  result = {63'd0, cmp_lt | cmp_eq};
				// Sign comes from A, magnitude from B
				FN_SGNJ:  result = {op_a[63], op_b[62:0]};
				FN_SGNJN: result = {~op_a[63], op_b[62:0]};
				FN_SGNJX: result = {op_a[63] ^ op_b[63], op_b[62:0]};
				default:  result = '0;
			endcase
		end
	end

endmodule

/* rtl/fpu_axil_read.sv */
// ====================
// FPU read side: result capture, STATUS and AXI4-Lite read channels
// ====================
module fpu_axil_read (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [fpu_axil_pkg::ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [31:0]                     rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready,
	input  logic                            start,
	input  logic                            done,
	input  logic                            busy,
	input  logic                            illegal,
	input  fpu_isa_pkg::value_t             result
);
	import fpu_axil_pkg::*;

	fpu_isa_pkg::value_t res_q;
	logic                ill_q;
	logic                done_q;
	logic                ar_acc;
	logic [31:0]         status;
	logic [31:0]         rd_word;
	logic [1:0]          rd_resp;

	// Result and illegal are held from one done to the next, so a read
	// while busy still sees the previous result
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			res_q  <= '0;
			ill_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (done) begin
				res_q <= result;
				ill_q <= illegal;
			end
			// Sticky done, cleared by the next start
			if (start)
				done_q <= 1'b0;
			else if (done)
				done_q <= 1'b1;
		end
	end

	always_comb begin
		status             = '0;
		status[ST_BUSY]    = busy;
		status[ST_DONE]    = done_q;
		status[ST_ILLEGAL] = ill_q;
	end

	// Operand and instruction registers are write-only and answer like
	// unmapped space
	always_comb begin
		rd_resp = RESP_OKAY;
		case (araddr)
			REG_STATUS: rd_word = status;
			REG_RES_LO: rd_word = res_q[31:0];
			REG_RES_HI: rd_word = res_q[63:32];
			default: begin
				rd_word = '0;
				rd_resp = RESP_SLVERR;
			end
		endcase
	end

	// ====================
	// Read handshake
	assign ar_acc = arvalid && arready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else if (ar_acc) begin
			arready <= 1'b0;
			rvalid  <= 1'b1;
		end else if (rvalid && rready) begin
			rvalid  <= 1'b0;
			arready <= 1'b1;
		end else if (!rvalid) begin
			arready <= 1'b1;
		end
	end

	// Data and response stay put until rready
	always_ff @(posedge clk) begin
		if (ar_acc) begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

endmodule

/* rtl/fpu_top.sv */
// ====================
// FPU top: AXI4-Lite register front end around the execute unit
// ====================
module fpu_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [fpu_axil_pkg::ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [31:0]                     wdata,
	input  logic [3:0]                      wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [fpu_axil_pkg::ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [31:0]                     rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready
);
	import fpu_isa_pkg::*;

	value_t     op_a, op_b, result;
	fpu_instr_t instr;
	logic       start, busy, done, illegal;

	fpu_axil_write u_write (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.busy(busy), .op_a(op_a), .op_b(op_b), .instr(instr), .start(start)
	);

	// Timing is kept apart from the datapath
	fpu_latency_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .instr(instr),
		.busy(busy), .done(done), .illegal(illegal)
	);

	fpu_exec u_exec (
		.clk(clk), .rst(rst), .start(start), .instr(instr),
		.op_a(op_a), .op_b(op_b), .result(result)
	);

	fpu_axil_read u_read (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.start(start), .done(done), .busy(busy), .illegal(illegal),
		.result(result)
	);

endmodule

/* tests/fpu_clk_gen.sv */
// ====================
// Testbench clock and reset source
// ====================
module fpu_clk_gen (
	output logic clk,
	output logic rst
);

	// Period of 40 time units
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset is held for the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* tests/fpu_assertions.sv */
// ====================
// Protocol checks on the FPU bus handshakes and the done/busy timing
// ====================
module fpu_assertions (
	input logic clk,
	input logic rst,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic start,
	input logic busy,
	input logic done
);

	// ====================
	// A raised valid stays up until its transfer
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");
	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped before wready");
	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");
	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// ====================
	// Done is a single-cycle pulse and busy ends with it
	done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> (!done && !busy))
		else $error("done was not a one-cycle pulse ending busy");

	// The write side never starts a second operation
	start_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy)
		else $error("start issued while busy");

endmodule

bind fpu_top fpu_assertions u_assertions (
	.clk(clk), .rst(rst),
	.awvalid(awvalid), .awready(awready),
	.wvalid(wvalid), .wready(wready),
	.bvalid(bvalid), .bready(bready),
	.arvalid(arvalid), .arready(arready),
	.rvalid(rvalid), .rready(rready),
	.start(start), .busy(busy), .done(done)
);

/* tests/fpu_tb.sv */
// ====================
// FPU testbench: drives the register interface through a table of
// operations plus protocol corner cases
// ====================
module fpu_tb;
	import fpu_isa_pkg::*;
	import fpu_axil_pkg::*;

	typedef struct {
		string      name;
		fpu_instr_t instr;
		value_t     a;
		value_t     b;
		value_t     exp;
		logic       ill;
		int         lat;
	} row_t;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [31:0]       wdata;
	logic [3:0]        wstrb;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [31:0]       rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;

	row_t rows[$];
	int   n_rows = 0;
	int   checks = 0;
	int   errors = 0;
	// Illegal flag of the last finished operation, as STATUS holds it
	logic last_ill;

	fpu_clk_gen u_clk (.clk(clk), .rst(rst));

	fpu_top DUT (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	// ====================
	// Compare tasks
	task automatic check_value(input string name, input value_t exp, input value_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected resp %b, actual resp %b", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected status %h, actual status %h", name, exp, act);
		end
	endtask

	// ====================
	// Bus driver tasks, each entered and left on a rising edge
	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= 4'hF;
		wvalid  <= 1'b1;
		do @(posedge clk); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		// bready stays high so the response moves on the edge it is seen
		do @(posedge clk); while (!bvalid);
		resp = bresp;
	endtask

	// Write with bready held low for a while so the response has to wait
	task automatic write_held(input string name, input logic [ADDR_W-1:0] addr,
			input logic [31:0] data, input int hold, output logic [1:0] resp);
		logic [1:0] resp0;
		bready  <= 1'b0;
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= 4'hF;
		wvalid  <= 1'b1;
		do @(posedge clk); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(posedge clk); while (!bvalid);
		resp0 = bresp;
		repeat (hold) begin
			@(posedge clk);
			checks++;
			if (!bvalid || bresp !== resp0) begin
				errors++;
				$display("%s: write response changed while bready was low", name);
			end
		end
		bready <= 1'b1;
		@(posedge clk);
		resp = resp0;
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		araddr  <= addr;
		arvalid <= 1'b1;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		do @(posedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
	endtask

	// Read with rready held low for a while so the response has to wait
	task automatic read_held(input string name, input logic [ADDR_W-1:0] addr,
			input int hold, output logic [31:0] data);
		logic [31:0] first;
		logic [1:0]  resp0;
		rready  <= 1'b0;
		araddr  <= addr;
		arvalid <= 1'b1;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		do @(posedge clk); while (!rvalid);
		first = rdata;
		resp0 = rresp;
		repeat (hold) begin
			@(posedge clk);
			checks++;
			if (!rvalid || rdata !== first || rresp !== resp0) begin
				errors++;
				$display("%s: read response changed while rready was low", name);
			end
		end
		rready <= 1'b1;
		@(posedge clk);
		data = first;
	endtask

	task automatic write_ok(input string name, input logic [ADDR_W-1:0] addr,
			input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_resp(name, RESP_OKAY, resp);
	endtask

	task automatic read_result(input string name, output value_t res);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [1:0]  resp;
		axi_read(REG_RES_LO, lo, resp);
		check_resp({name, " res_lo"}, RESP_OKAY, resp);
		axi_read(REG_RES_HI, hi, resp);
		check_resp({name, " res_hi"}, RESP_OKAY, resp);
		res = {hi, lo};
	endtask

	// Poll STATUS until done shows or the read budget runs out
	task automatic poll_done(input string name, output logic [31:0] st);
		logic [1:0] resp;
		int         tries;
		tries = 0;
		do begin
			axi_read(REG_STATUS, st, resp);
			tries++;
		end while (!st[ST_DONE] && tries < 16);
		if (!st[ST_DONE]) begin
			errors++;
			$display("%s: operation never reported done", name);
		end
	endtask

	// ====================
	// Instruction words and expected values
	function automatic fpu_instr_t one_op(input logic [4:0] fn);
		fpu_instr_t i;
		i          = '0;
		i.f1.opcode = OP_FLT;
		i.f1.func2  = FN_FLT1;
		i.f1.func1  = fn;
		return i;
	endfunction

	function automatic fpu_instr_t two_op(input logic [4:0] fn);
		fpu_instr_t i;
		i           = '0;
		i.f2.opcode = OP_FLT;
		i.f2.func2  = fn;
		return i;
	endfunction

	function automatic logic nan_of(input value_t x);
		return x[62:52] == 11'h7FF && x[51:0] != 52'd0;
	endfunction

	// Maps a double onto an unsigned key with the same ordering
	// Both zeros land on the same key
	function automatic logic [63:0] order_key(input value_t x);
		if (x[62:0] == 63'd0)
			return 64'h8000_0000_0000_0000;
		if (x[63])
			return ~x;
		return {1'b1, x[62:0]};
	endfunction

	// Expected result of the sign and compare functions
	function automatic value_t model_simple(input fpu_instr_t i, input value_t a,
			input value_t b);
		logic unordered;
		logic eq;
		logic lt;
		unordered = nan_of(a) || nan_of(b);
		eq        = !unordered && order_key(a) == order_key(b);
		lt        = !unordered && order_key(a) < order_key(b);
		if (i.f2.func2 == FN_FLT1)
			return (i.f1.func1 == FN_FABS) ? {1'b0, a[62:0]} : {!a[63], a[62:0]};
		case (i.f2.func2)
			FN_SGNJ:  return {a[63], b[62:0]};
			FN_SGNJN: return {!a[63], b[62:0]};
			FN_SGNJX: return {a[63] ^ b[63], b[62:0]};
			FN_FSEQ:  return value_t'(eq);
			FN_FSNE:  return value_t'(!eq);
			FN_FSLT:  return value_t'(lt);
			default:  return value_t'(lt || eq);
		endcase
	endfunction

	task automatic add_row(input string name, input fpu_instr_t instr, input value_t a,
			input value_t b, input value_t exp, input logic ill, input int lat);
		row_t r;
		r.name  = name;
		r.instr = instr;
		r.a     = a;
		r.b     = b;
		r.exp   = exp;
		r.ill   = ill;
		r.lat   = lat;
		rows.push_back(r);
	endtask

	task automatic build_table();
		fpu_instr_t codes[9];
		fpu_instr_t bad;
		value_t     a;
		value_t     b;
		// Sign functions
		add_row("fabs", one_op(FN_FABS), 64'hC004_0000_0000_0000, 0,
			64'h4004_0000_0000_0000, 0, 1);
		add_row("fneg", one_op(FN_FNEG), 64'h3FF0_0000_0000_0000, 0,
			64'hBFF0_0000_0000_0000, 0, 1);
		add_row("sgnj", two_op(FN_SGNJ), 64'hC008_0000_0000_0000,
			64'h4004_0000_0000_0000, 64'hC004_0000_0000_0000, 0, 1);
		add_row("sgnjn", two_op(FN_SGNJN), 64'hC008_0000_0000_0000,
			64'h4004_0000_0000_0000, 64'h4004_0000_0000_0000, 0, 1);
		add_row("sgnjx", two_op(FN_SGNJX), 64'hC008_0000_0000_0000,
			64'hC004_0000_0000_0000, 64'h4004_0000_0000_0000, 0, 1);
		// Compares, signed zero and NaN cases
		add_row("fseq_zeros", two_op(FN_FSEQ), 0, 64'h8000_0000_0000_0000, 1, 0, 1);
		add_row("fseq_nan", two_op(FN_FSEQ), 64'h7FF8_0000_0000_0000,
			64'h7FF8_0000_0000_0000, 0, 0, 1);
		add_row("fsne_nan", two_op(FN_FSNE), 64'h7FF8_0000_0000_0000,
			64'h3FF0_0000_0000_0000, 1, 0, 1);
		add_row("fslt_mixed", two_op(FN_FSLT), 64'hC004_0000_0000_0000,
			64'h3FF0_0000_0000_0000, 1, 0, 1);
		add_row("fslt_neg", two_op(FN_FSLT), 64'hC004_0000_0000_0000,
			64'hC008_0000_0000_0000, 0, 0, 1);
		add_row("fsle_equal", two_op(FN_FSLE), 64'h4004_0000_0000_0000,
			64'h4004_0000_0000_0000, 1, 0, 1);
		add_row("fsle_nan", two_op(FN_FSLE), 64'h3FF0_0000_0000_0000,
			64'h7FF0_0000_0000_0001, 0, 0, 1);
		// Classification
		add_row("isnan_snan", one_op(FN_ISNAN), 64'h7FF0_0000_0000_0001, 0, 1, 0, 1);
		add_row("isnan_inf", one_op(FN_ISNAN), 64'h7FF0_0000_0000_0000, 0, 0, 0, 1);
		add_row("finite_ninf", one_op(FN_FINITE), 64'hFFF0_0000_0000_0000, 0, 0, 0, 1);
		add_row("finite_num", one_op(FN_FINITE), 64'h400E_0000_0000_0000, 0, 1, 0, 1);
		// Truncate toward zero
		add_row("trunc_3p75", one_op(FN_FTRUNC), 64'h400E_0000_0000_0000, 0,
			64'h4008_0000_0000_0000, 0, 3);
		add_row("trunc_m2p5", one_op(FN_FTRUNC), 64'hC004_0000_0000_0000, 0,
			64'hC000_0000_0000_0000, 0, 3);
		add_row("trunc_0p75", one_op(FN_FTRUNC), 64'h3FE8_0000_0000_0000, 0, 0, 0, 3);
		add_row("trunc_m0p5", one_op(FN_FTRUNC), 64'hBFE0_0000_0000_0000, 0,
			64'h8000_0000_0000_0000, 0, 3);
		add_row("trunc_large", one_op(FN_FTRUNC), 64'h43B0_0000_0000_0001, 0,
			64'h43B0_0000_0000_0001, 0, 3);
		add_row("trunc_inf", one_op(FN_FTRUNC), 64'h7FF0_0000_0000_0000, 0,
			64'h7FF0_0000_0000_0000, 0, 3);
		add_row("trunc_nan", one_op(FN_FTRUNC), 64'h7FF8_0000_0000_0123, 0,
			64'h7FF8_0000_0000_0123, 0, 3);
		add_row("trunc_one", one_op(FN_FTRUNC), 64'h3FF0_0000_0000_0000, 0,
			64'h3FF0_0000_0000_0000, 0, 3);
		// Single to double, with junk in A's upper word
		add_row("cvt_one", one_op(FN_FCVTS2D), 64'hDEAD_BEEF_3F80_0000, 0,
			64'h3FF0_0000_0000_0000, 0, 2);
		add_row("cvt_m1p5", one_op(FN_FCVTS2D), 64'hDEAD_BEEF_BFC0_0000, 0,
			64'hBFF8_0000_0000_0000, 0, 2);
		add_row("cvt_two", one_op(FN_FCVTS2D), 64'h0000_0000_4000_0000, 0,
			64'h4000_0000_0000_0000, 0, 2);
		add_row("cvt_inf", one_op(FN_FCVTS2D), 64'h0000_0000_7F80_0000, 0,
			64'h7FF0_0000_0000_0000, 0, 2);
		add_row("cvt_snan", one_op(FN_FCVTS2D), 64'h0000_0000_7F80_0001, 0,
			64'h7FF8_0000_2000_0000, 0, 2);
		add_row("cvt_subnorm", one_op(FN_FCVTS2D), 64'h0000_0000_8000_0001, 0,
			64'h8000_0000_0000_0000, 0, 2);
		// Illegal codes finish in one cycle with a zero result
		add_row("bad_opcode", fpu_instr_t'(32'h0000_0013), 64'h3FF0_0000_0000_0000, 0,
			0, 1, 1);
		add_row("bad_func2", two_op(5'h1F), 64'h3FF0_0000_0000_0000, 0, 0, 1, 1);
		add_row("bad_func1", one_op(5'h1F), 64'h3FF0_0000_0000_0000, 0, 0, 1, 1);
		// Random operands over the sign and compare functions
		codes = '{one_op(FN_FABS), one_op(FN_FNEG), two_op(FN_SGNJ), two_op(FN_SGNJN),
			two_op(FN_SGNJX), two_op(FN_FSEQ), two_op(FN_FSNE), two_op(FN_FSLT),
			two_op(FN_FSLE)};
		for (int i = 0; i < 18; i++) begin
			a = {$urandom, $urandom};
			// Every third pair is equal so the equality paths are reached
			b = (i % 3 == 2) ? a : {$urandom, $urandom};
			add_row($sformatf("rand_%0d", i), codes[i % 9], a, b,
				model_simple(codes[i % 9], a, b), 0, 1);
		end
		n_rows = rows.size();
	endtask

	// ====================
	// One table row: load, start, check timing, wait, read back
	task automatic run_row(input row_t r);
		logic [31:0] st;
		logic [1:0]  resp;
		value_t      res;
		write_ok({r.name, " a_lo"}, REG_A_LO, r.a[31:0]);
		write_ok({r.name, " a_hi"}, REG_A_HI, r.a[63:32]);
		write_ok({r.name, " b_lo"}, REG_B_LO, r.b[31:0]);
		write_ok({r.name, " b_hi"}, REG_B_HI, r.b[63:32]);
		write_ok({r.name, " instr"}, REG_INSTR, r.instr);
		// Sampled in the last busy cycle, where illegal still shows the previous row
		repeat (r.lat - 1) @(posedge clk);
		axi_read(REG_STATUS, st, resp);
		check_status({r.name, " busy"}, {29'd0, last_ill, 2'b01}, st);
		poll_done(r.name, st);
		check_status({r.name, " done"}, {29'd0, r.ill, 2'b10}, st);
		read_result(r.name, res);
		check_value(r.name, r.exp, res);
		last_ill = r.ill;
	endtask

	// ====================
	// Main sequence
	initial begin
		logic [31:0] data;
		logic [31:0] st;
		logic [1:0]  resp;
		value_t      res;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b1;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b1;
		last_ill = 1'b0;
		void'($urandom(32'h116a_4a39));
		build_table();
		wait (!rst);
		@(posedge clk);

		// Reset state
		axi_read(REG_STATUS, data, resp);
		check_status("reset status", 32'h0, data);
		read_result("reset res", res);
		check_value("reset res", 64'd0, res);

		foreach (rows[i])
			run_row(rows[i]);

		// A second INSTR write while truncate runs is refused
		write_ok("busy a_lo", REG_A_LO, 32'h0);
		write_ok("busy a_hi", REG_A_HI, 32'h400E_0000);
		write_ok("busy instr", REG_INSTR, one_op(FN_FTRUNC));
		axi_write(REG_INSTR, one_op(FN_FNEG), resp);
		check_resp("instr while busy", RESP_SLVERR, resp);
		poll_done("busy trunc", st);
		check_status("busy trunc", 32'h2, st);
		read_result("busy trunc", res);
		check_value("busy trunc", 64'h4008_0000_0000_0000, res);

		// Read-only, unaligned and write-only offsets
		axi_write(REG_STATUS, 32'hFFFF_FFFF, resp);
		check_resp("write status", RESP_SLVERR, resp);
		axi_write(5'h02, 32'h1234_5678, resp);
		check_resp("write unaligned", RESP_SLVERR, resp);
		axi_read(REG_A_LO, data, resp);
		check_resp("read a_lo", RESP_SLVERR, resp);
		check_status("read a_lo data", 32'h0, data);

		// Back-pressure on the write response channel
		write_held("held b_lo", REG_B_LO, 32'h0, 4, resp);
		check_resp("held b_lo", RESP_OKAY, resp);

		// Back-pressure on the read data channel
		read_held("held res_hi", REG_RES_HI, 5, data);
		check_status("held res_hi", 32'h4008_0000, data);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		longint limit;
		wait (n_rows != 0);
		limit = (longint'(n_rows) * 40 + 200) * 40;
		#(limit);
		$display("Timeout: the run did not finish within %0d time units", limit);
		$display("Checks failed");
		$finish;
	end

endmodule

/* sim.f */
rtl/fpu_isa_pkg.sv
rtl/fpu_axil_pkg.sv
rtl/fpu_axil_write.sv
rtl/fpu_latency_ctrl.sv
rtl/fpu_exec.sv
rtl/fpu_axil_read.sv
rtl/fpu_top.sv
tests/fpu_clk_gen.sv
tests/fpu_assertions.sv
tests/fpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module fpu_tb -f sim.f -o Vfpu_tb

set +e
./obj_dir/Vfpu_tb > sim.log 2>&1
set -e
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "FAIL: run ended early"
	exit 1
fi
echo "PASS"
